/* logic/rv_id_settings.svh */
`ifndef RV_ID_SETTINGS_SVH
`define RV_ID_SETTINGS_SVH

// ====================
// RV32I decode stage widths
// ====================

// Data path width
`define RV_XLEN 32

// Register index width and register count
`define RV_REG_AW 5
`define RV_NREGS 32

// Major opcode field, bits [6:0] of the instruction word
`define RV_OPC_W 7

`endif

/* logic/rv_id_pkg.sv */
`include "rv_id_settings.svh"

package rv_id_pkg;

  // ====================
  // Encodings
  // ====================

  typedef enum logic [`RV_OPC_W-1:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [1:0] {
    RES_ALU = 2'd0,
    RES_MEM = 2'd1,
    RES_PC4 = 2'd2
  } res_src_e;

  typedef enum logic [1:0] {
    ALU_A_RS1  = 2'd0,
    ALU_A_PC   = 2'd1,
    ALU_A_ZERO = 2'd2
  } alu_a_e;

  // ====================
  // Instruction formats
  // ====================

  typedef struct packed {
    logic [6:0]            funct7;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_OPC_W-1:0]  opcode;
  } fmt_r_t;

  typedef struct packed {
    logic [11:0]           imm_11_0;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_OPC_W-1:0]  opcode;
  } fmt_i_t;

  typedef struct packed {
    logic [6:0]            imm_11_5;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_4_0;
    logic [`RV_OPC_W-1:0]  opcode;
  } fmt_s_t;

  typedef struct packed {
    logic                  imm_12;
    logic [5:0]            imm_10_5;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [3:0]            imm_4_1;
    logic                  imm_11;
    logic [`RV_OPC_W-1:0]  opcode;
  } fmt_b_t;

  typedef struct packed {
    logic [19:0]           imm_31_12;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_OPC_W-1:0]  opcode;
  } fmt_u_t;

  typedef struct packed {
    logic                  imm_20;
    logic [9:0]            imm_10_1;
    logic                  imm_11;
    logic [7:0]            imm_19_12;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_OPC_W-1:0]  opcode;
  } fmt_j_t;

  // Same 32-bit word, six views
  typedef union packed {
    fmt_r_t r;
    fmt_i_t i;
    fmt_s_t s;
    fmt_b_t b;
    fmt_u_t u;
    fmt_j_t j;
  } instr_u;

  // ====================
  // Stage bundles
  // ====================

  typedef struct packed {
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       is_branch;
    logic       is_jmp;
    logic       is_jal;
    logic       is_jalr;
    logic       trap;
    alu_a_e     alu_a_src;
    logic       alu_b_src;   // 1 selects the immediate
    logic [1:0] alu_instr;
    res_src_e   res_src;
    logic       jb_tgt_src;  // 1 selects rs1 as jump base
  } ctrl_t;

  typedef struct packed {
    ctrl_t                 ctrl;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [`RV_XLEN-1:0]   imm;
  } dec_t;

  typedef struct packed {
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    logic                  rs1_used;
    logic                  rs2_used;
  } src_use_t;

  typedef struct packed {
    logic                  we;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   data;
  } wb_t;

  typedef struct packed {
    logic                  we;
    logic [`RV_REG_AW-1:0] rd;
    logic                  is_load;
    logic [`RV_XLEN-1:0]   result;
    logic [`RV_XLEN-1:0]   ld_data;
  } mem_fwd_t;

  typedef struct packed {
    logic                valid;
    instr_u              instr;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_plus4;
  } fetch_t;

  typedef struct packed {
    dec_t                dec;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    instr_u              instr;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_plus4;
  } id_ex_t;

endpackage

/* logic/rv_decoder.sv */
`include "rv_id_settings.svh"

module rv_decoder import rv_id_pkg::*; (
  input  instr_u   instr_i,
  output dec_t     dec_o,
  output src_use_t src_o
);

  // ====================
  // Immediates
  // ====================

  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;

  assign imm_i = {{(`RV_XLEN-12){instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
  assign imm_s = {{(`RV_XLEN-12){instr_i.s.imm_11_5[6]}}, instr_i.s.imm_11_5,
                  instr_i.s.imm_4_0};
  assign imm_b = {{(`RV_XLEN-12){instr_i.b.imm_12}}, instr_i.b.imm_11,
                  instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
  assign imm_u = {instr_i.u.imm_31_12, 12'b0};
  assign imm_j = {{(`RV_XLEN-20){instr_i.j.imm_20}}, instr_i.j.imm_19_12,
                  instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};

  // ====================
  // Control decode
  // ====================

  always_comb begin
    dec_o        = '0;
    dec_o.rd     = instr_i.r.rd;
    dec_o.rs1    = instr_i.r.rs1;
    dec_o.rs2    = instr_i.r.rs2;
    dec_o.funct3 = instr_i.r.funct3;
    dec_o.funct7 = instr_i.r.funct7;

    src_o          = '0;
    src_o.rs1      = instr_i.r.rs1;
    src_o.rs2      = instr_i.r.rs2;

    case (instr_i.r.opcode)
      OPC_LUI: begin
        // Immediate added to zero
        dec_o.ctrl.reg_write = 1'b1;
        dec_o.ctrl.alu_a_src = ALU_A_ZERO;
        dec_o.ctrl.alu_b_src = 1'b1;
        dec_o.imm            = imm_u;
      end
      OPC_AUIPC: begin
        dec_o.ctrl.reg_write = 1'b1;
        dec_o.ctrl.alu_a_src = ALU_A_PC;
        dec_o.ctrl.alu_b_src = 1'b1;
        dec_o.imm            = imm_u;
      end
      OPC_JAL: begin
        dec_o.ctrl.reg_write = 1'b1;
        dec_o.ctrl.is_jmp    = 1'b1;
        dec_o.ctrl.is_jal    = 1'b1;
        dec_o.ctrl.alu_a_src = ALU_A_PC;
        dec_o.ctrl.alu_b_src = 1'b1;
        dec_o.ctrl.res_src   = RES_PC4;
        dec_o.imm            = imm_j;
      end
      OPC_JALR: begin
        dec_o.ctrl.reg_write  = 1'b1;
        dec_o.ctrl.is_jmp     = 1'b1;
        dec_o.ctrl.is_jalr    = 1'b1;
        dec_o.ctrl.alu_b_src  = 1'b1;
        dec_o.ctrl.res_src    = RES_PC4;
        dec_o.ctrl.jb_tgt_src = 1'b1;
        dec_o.imm             = imm_i;
        src_o.rs1_used        = 1'b1;
      end
      OPC_BRANCH: begin
        dec_o.ctrl.is_branch = 1'b1;
        dec_o.ctrl.alu_instr = 2'b01;
        dec_o.imm            = imm_b;
        src_o.rs1_used       = 1'b1;
        src_o.rs2_used       = 1'b1;
      end
      OPC_LOAD: begin
        dec_o.ctrl.reg_write = 1'b1;
        dec_o.ctrl.mem_read  = 1'b1;
        dec_o.ctrl.alu_b_src = 1'b1;
        dec_o.ctrl.res_src   = RES_MEM;
        dec_o.imm            = imm_i;
        src_o.rs1_used       = 1'b1;
      end
      OPC_STORE: begin
        dec_o.ctrl.mem_write = 1'b1;
        dec_o.ctrl.alu_b_src = 1'b1;
        dec_o.imm            = imm_s;
        src_o.rs1_used       = 1'b1;
        src_o.rs2_used       = 1'b1;
      end
      OPC_OP_IMM: begin
        dec_o.ctrl.reg_write = 1'b1;
        dec_o.ctrl.alu_b_src = 1'b1;
        dec_o.ctrl.alu_instr = 2'b11;
        dec_o.imm            = imm_i;
        src_o.rs1_used       = 1'b1;
      end
      OPC_OP: begin
        dec_o.ctrl.reg_write = 1'b1;
        dec_o.ctrl.alu_instr = 2'b10;
        src_o.rs1_used       = 1'b1;
        src_o.rs2_used       = 1'b1;
      end
      default: begin
        // Unsupported opcode, only the trap survives
        dec_o.ctrl.trap = 1'b1;
      end
    endcase
  end

endmodule

/* logic/rv_regfile.sv */
`include "rv_id_settings.svh"

module rv_regfile import rv_id_pkg::*; (
  input  logic                  clk,
  input  logic [`RV_REG_AW-1:0] rs1_addr_i,
  input  logic [`RV_REG_AW-1:0] rs2_addr_i,
  input  wb_t                   wb_i,
  input  logic                  dmem_stall_i,
  output logic [`RV_XLEN-1:0]   rs1_data_o,
  output logic [`RV_XLEN-1:0]   rs2_data_o
);

  // ====================
  // Storage
  // ====================

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];
  logic                wr_en;

  // WB result is not committed while the data memory stalls
  assign wr_en = wb_i.we && !dmem_stall_i && (wb_i.rd != '0);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  // ====================
  // Read ports
  // ====================

  // x0 is hardwired, entry 0 is never written
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

/* logic/rv_operand_fwd.sv */
`include "rv_id_settings.svh"

module rv_operand_fwd import rv_id_pkg::*; (
  input  src_use_t            src_i,
  input  logic [`RV_XLEN-1:0] rs1_raw_i,
  input  logic [`RV_XLEN-1:0] rs2_raw_i,
  input  mem_fwd_t            mem_i,
  input  wb_t                 wb_i,
  output logic [`RV_XLEN-1:0] rs1_data_o,
  output logic [`RV_XLEN-1:0] rs2_data_o
);

  // Priority: x0, then MEM, then WB, then the register file
  function automatic logic [`RV_XLEN-1:0] fwd_pick(
    input logic [`RV_REG_AW-1:0] addr,
    input logic [`RV_XLEN-1:0]   raw,
    input mem_fwd_t              mem,
    input wb_t                   wb
  );
    logic [`RV_XLEN-1:0] val;
    if (addr == '0) begin
      val = '0;
    end else if (mem.we && (mem.rd == addr)) begin
      // A load in MEM has its data ready, not just the address
      val = mem.is_load ? mem.ld_data : mem.result;
    end else if (wb.we && (wb.rd == addr)) begin
      // Also covers the write landing in the regfile this cycle
      val = wb.data;
    end else begin
      val = raw;
    end
    return val;
  endfunction

  // ====================
  // Operand select
  // ====================

  assign rs1_data_o = fwd_pick(src_i.rs1, rs1_raw_i, mem_i, wb_i);
  assign rs2_data_o = fwd_pick(src_i.rs2, rs2_raw_i, mem_i, wb_i);

endmodule

/* logic/rv_id_ex_reg.sv */
`include "rv_id_settings.svh"

module rv_id_ex_reg import rv_id_pkg::*; (
  input  logic                clk,
  input  logic                arst_n_i,
  input  dec_t                dec_i,
  input  logic [`RV_XLEN-1:0] rs1_data_i,
  input  logic [`RV_XLEN-1:0] rs2_data_i,
  input  fetch_t              fetch_i,
  input  logic                stall_i,
  input  logic                bubble_i,
  input  logic                flush_i,
  input  logic                m_ready_i,
  output id_ex_t              ex_o,
  output logic                m_valid_o
);

  // Kills the side-effect flags, the routing fields stay
  function automatic ctrl_t clear_flags(input ctrl_t c);
    ctrl_t r;
    r           = c;
    r.reg_write = 1'b0;
    r.mem_read  = 1'b0;
    r.mem_write = 1'b0;
    r.is_branch = 1'b0;
    r.is_jmp    = 1'b0;
    r.is_jal    = 1'b0;
    r.is_jalr   = 1'b0;
    r.trap      = 1'b0;
    return r;
  endfunction

  logic   hold;
  ctrl_t  ctrl_q;
  id_ex_t pay_d;
  id_ex_t pay_q;

  // Back-pressure from EX or a stall from the hazard unit
  assign hold = stall_i || !m_ready_i;

  // ====================
  // Valid and control
  // ====================

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      m_valid_o <= 1'b0;
      ctrl_q    <= '0;
    end else if (flush_i) begin
      m_valid_o <= 1'b0;
      ctrl_q    <= clear_flags(ctrl_q);
    end else if (!hold) begin
      if (bubble_i) begin
        m_valid_o <= 1'b0;
        ctrl_q    <= clear_flags(dec_i.ctrl);
      end else begin
        m_valid_o <= fetch_i.valid;
        ctrl_q    <= dec_i.ctrl;
      end
    end
  end

  // ====================
  // Payload
  // ====================

  assign pay_d = '{
    dec:      dec_i,
    rs1_data: rs1_data_i,
    rs2_data: rs2_data_i,
    instr:    fetch_i.instr,
    pc:       fetch_i.pc,
    pc_plus4: fetch_i.pc_plus4
  };

  // Bubbles load too, the contents are don't-care with valid low
  always_ff @(posedge clk) begin
    if (!flush_i && !hold) begin
      pay_q <= pay_d;
    end
  end

  always_comb begin
    ex_o          = pay_q;
    ex_o.dec.ctrl = ctrl_q;
  end

  // Hazard unit must not flush an instruction EX is still holding
  a_no_flush_on_backpressure: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    !(m_valid_o && !m_ready_i && flush_i)
  );

  // Held stage keeps its outputs, payload only matters when valid
  a_hold_stable: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    (hold && !flush_i) |=> $stable(m_valid_o) && $stable(ex_o.dec.ctrl) &&
                           (!m_valid_o || $stable(ex_o))
  );

endmodule

/* logic/rv_stage_id.sv */
`include "rv_id_settings.svh"

module rv_stage_id import rv_id_pkg::*; (
  input  logic     clk,
  input  logic     arst_n_i,
  input  fetch_t   fetch_i,
  input  wb_t      wb_i,
  input  mem_fwd_t mem_i,
  input  logic     stall_id_i,
  input  logic     data_hazard_i,
  input  logic     flush_i,
  input  logic     dmem_stall_i,
  input  logic     m_ready_i,
  output id_ex_t   ex_o,
  output logic     m_valid_o,
  output src_use_t src_o
);

  dec_t                dec;
  logic [`RV_XLEN-1:0] rs1_raw;
  logic [`RV_XLEN-1:0] rs2_raw;
  logic [`RV_XLEN-1:0] rs1_fwd;
  logic [`RV_XLEN-1:0] rs2_fwd;

  // ====================
  // Decode and operands
  // ====================

  rv_decoder i_rv_decoder (
    .instr_i (fetch_i.instr),
    .dec_o   (dec),
    .src_o   (src_o)
  );

  rv_regfile i_rv_regfile (
    .clk          (clk),
    .rs1_addr_i   (src_o.rs1),
    .rs2_addr_i   (src_o.rs2),
    .wb_i         (wb_i),
    .dmem_stall_i (dmem_stall_i),
    .rs1_data_o   (rs1_raw),
    .rs2_data_o   (rs2_raw)
  );

  rv_operand_fwd i_rv_operand_fwd (
    .src_i      (src_o),
    .rs1_raw_i  (rs1_raw),
    .rs2_raw_i  (rs2_raw),
    .mem_i      (mem_i),
    .wb_i       (wb_i),
    .rs1_data_o (rs1_fwd),
    .rs2_data_o (rs2_fwd)
  );

  // ====================
  // ID/EX register
  // ====================

  // A data hazard turns the captured instruction into a bubble
  rv_id_ex_reg i_rv_id_ex_reg (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .dec_i      (dec),
    .rs1_data_i (rs1_fwd),
    .rs2_data_i (rs2_fwd),
    .fetch_i    (fetch_i),
    .stall_i    (stall_id_i),
    .bubble_i   (data_hazard_i),
    .flush_i    (flush_i),
    .m_ready_i  (m_ready_i),
    .ex_o       (ex_o),
    .m_valid_o  (m_valid_o)
  );

endmodule

/* tb/tb_rv_stage_id.sv */
`include "rv_id_settings.svh"

module tb_rv_stage_id import rv_id_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES   = 10;
  localparam int RF_INIT_CYCLES = 31;
  localparam int RF_CYCLES      = 150;
  localparam int DEC_CYCLES     = 300;
  localparam int FWD_CYCLES     = 300;
  localparam int PIPE_CYCLES    = 400;
  localparam int TIMEOUT_CYCLES = 4 * (RESET_CYCLES + RF_INIT_CYCLES + RF_CYCLES +
                                       DEC_CYCLES + FWD_CYCLES + PIPE_CYCLES);

  logic     clk;
  logic     arst_n_i;
  fetch_t   fetch;
  wb_t      wb;
  mem_fwd_t mem;
  logic     stall_id;
  logic     data_hazard;
  logic     flush;
  logic     dmem_stall;
  logic     m_ready;
  id_ex_t   ex;
  logic     m_valid;
  src_use_t src;

  // Reference state
  logic [`RV_XLEN-1:0] shadow_regs [`RV_NREGS];
  id_ex_t              exp_ex;
  logic                exp_valid;
  int                  pass_cnt;
  int                  fail_cnt;
  int                  cycle_cnt;

  opcode_e kept_ops [9] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                            OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP};

  rv_stage_id i_rv_stage_id (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .fetch_i       (fetch),
    .wb_i          (wb),
    .mem_i         (mem),
    .stall_id_i    (stall_id),
    .data_hazard_i (data_hazard),
    .flush_i       (flush),
    .dmem_stall_i  (dmem_stall),
    .m_ready_i     (m_ready),
    .ex_o          (ex),
    .m_valid_o     (m_valid),
    .src_o         (src)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ====================
  // Reference model
  // ====================

  function automatic bit chance(input int pct);
    return $urandom_range(99) < pct;
  endfunction

  function automatic bit is_kept(input logic [6:0] opc);
    bit hit;
    hit = 1'b0;
    foreach (kept_ops[k]) begin
      if (opc == kept_ops[k]) hit = 1'b1;
    end
    return hit;
  endfunction

  function automatic dec_t ref_decode(input logic [31:0] w);
    dec_t d;
    d        = '0;
    d.rd     = w[11:7];
    d.funct3 = w[14:12];
    d.rs1    = w[19:15];
    d.rs2    = w[24:20];
    d.funct7 = w[31:25];
    if (!is_kept(w[6:0])) begin
      d.ctrl.trap = 1'b1;
    end else begin
      d.ctrl.reg_write = (w[6:0] != OPC_BRANCH) && (w[6:0] != OPC_STORE);
      d.ctrl.alu_b_src = (w[6:0] != OPC_BRANCH) && (w[6:0] != OPC_OP);
    end
    case (w[6:0])
      OPC_LUI: begin
        d.ctrl.alu_a_src = ALU_A_ZERO;
        d.imm            = {w[31:12], 12'b0};
      end
      OPC_AUIPC: begin
        d.ctrl.alu_a_src = ALU_A_PC;
        d.imm            = {w[31:12], 12'b0};
      end
      OPC_JAL: begin
        d.ctrl.is_jmp    = 1'b1;
        d.ctrl.is_jal    = 1'b1;
        d.ctrl.alu_a_src = ALU_A_PC;
        d.ctrl.res_src   = RES_PC4;
        d.imm            = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      OPC_JALR: begin
        d.ctrl.is_jmp     = 1'b1;
        d.ctrl.is_jalr    = 1'b1;
        d.ctrl.res_src    = RES_PC4;
        d.ctrl.jb_tgt_src = 1'b1;
        d.imm             = {{20{w[31]}}, w[31:20]};
      end
      OPC_BRANCH: begin
        d.ctrl.is_branch = 1'b1;
        d.ctrl.alu_instr = 2'b01;
        d.imm            = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      end
      OPC_LOAD: begin
        d.ctrl.mem_read = 1'b1;
        d.ctrl.res_src  = RES_MEM;
        d.imm           = {{20{w[31]}}, w[31:20]};
      end
      OPC_STORE: begin
        d.ctrl.mem_write = 1'b1;
        d.imm            = {{20{w[31]}}, w[31:25], w[11:7]};
      end
      OPC_OP_IMM: begin
        d.ctrl.alu_instr = 2'b11;
        d.imm            = {{20{w[31]}}, w[31:20]};
      end
      OPC_OP: d.ctrl.alu_instr = 2'b10;
      default: d.imm = '0;
    endcase
    return d;
  endfunction

  function automatic src_use_t ref_src(input logic [31:0] w);
    src_use_t s;
    s.rs1      = w[19:15];
    s.rs2      = w[24:20];
    s.rs1_used = is_kept(w[6:0]) && (w[6:0] != OPC_LUI) && (w[6:0] != OPC_AUIPC) &&
                 (w[6:0] != OPC_JAL);
    s.rs2_used = (w[6:0] == OPC_BRANCH) || (w[6:0] == OPC_STORE) || (w[6:0] == OPC_OP);
    return s;
  endfunction

  // Priority MEM over WB over the register file
  // x0 always reads zero
  function automatic logic [`RV_XLEN-1:0] ref_operand(input logic [`RV_REG_AW-1:0] a);
    if (a == '0) return '0;
    if (mem.we && mem.rd == a) return mem.is_load ? mem.ld_data : mem.result;
    if (wb.we && wb.rd == a) return wb.data;
    return shadow_regs[a];
  endfunction

  function automatic ctrl_t strip_side_effects(input ctrl_t c);
    ctrl_t r;
    r = c;
    {r.reg_write, r.mem_read, r.mem_write, r.is_branch} = 4'b0;
    {r.is_jmp, r.is_jal, r.is_jalr, r.trap} = 4'b0;
    return r;
  endfunction

  // ====================
  // Compare tasks
  // ====================

  task automatic report_mismatch(input string sig, input logic [255:0] exp,
                                 input logic [255:0] got);
    $display("FAILED %s exp=%0h got=%0h", sig, exp, got);
    fail_cnt++;
  endtask

  task automatic check_valid(input string sig, input logic exp, input logic got);
    if (exp !== got) report_mismatch(sig, 256'(exp), 256'(got));
    else pass_cnt++;
  endtask

  task automatic check_ctrl(input string sig, input ctrl_t exp, input ctrl_t got);
    if (exp !== got) report_mismatch(sig, 256'(exp), 256'(got));
    else pass_cnt++;
  endtask

  task automatic check_dec(input string sig, input dec_t exp, input dec_t got);
    if (exp !== got) report_mismatch(sig, 256'(exp), 256'(got));
    else pass_cnt++;
  endtask

  task automatic check_src(input string sig, input src_use_t exp, input src_use_t got);
    if (exp !== got) report_mismatch(sig, 256'(exp), 256'(got));
    else pass_cnt++;
  endtask

  task automatic check_ex(input id_ex_t exp, input id_ex_t got);
    if (exp.rs1_data !== got.rs1_data)
      report_mismatch("ex_o.rs1_data", 256'(exp.rs1_data), 256'(got.rs1_data));
    else if (exp.rs2_data !== got.rs2_data)
      report_mismatch("ex_o.rs2_data", 256'(exp.rs2_data), 256'(got.rs2_data));
    else if (exp.instr !== got.instr)
      report_mismatch("ex_o.instr", 256'(exp.instr), 256'(got.instr));
    else if ({exp.pc, exp.pc_plus4} !== {got.pc, got.pc_plus4})
      report_mismatch("ex_o.pc", 256'({exp.pc, exp.pc_plus4}), 256'({got.pc, got.pc_plus4}));
    else pass_cnt++;
  endtask

  // ====================
  // Stimulus
  // ====================

  function automatic logic [31:0] rand_instr(input int invalid_pct);
    logic [31:0] w;
    w = $urandom();
    if (chance(invalid_pct)) begin
      while (is_kept(w[6:0])) w[6:0] = 7'($urandom_range(127));
    end else begin
      w[6:0] = kept_ops[$urandom_range(8)];
    end
    return w;
  endfunction

  function automatic logic [4:0] pick_rd(input logic [4:0] a, input logic [4:0] b);
    int r;
    r = $urandom_range(99);
    if (r < 35) return a;
    if (r < 60) return b;
    return 5'($urandom_range(31));
  endfunction

  task automatic drive_fetch(input logic valid, input logic [31:0] w);
    fetch.valid    = valid;
    fetch.instr    = w;
    fetch.pc       = $urandom() & 32'hFFFF_FFFC;
    fetch.pc_plus4 = fetch.pc + 32'd4;
  endtask

  task automatic drive_bypass_sources();
    mem.we      = chance(50);
    mem.rd      = pick_rd(fetch.instr[19:15], fetch.instr[24:20]);
    mem.is_load = chance(50);
    mem.result  = $urandom();
    mem.ld_data = $urandom();
    wb.we       = chance(60);
    wb.rd       = pick_rd(fetch.instr[19:15], fetch.instr[24:20]);
    wb.data     = $urandom();
    dmem_stall  = chance(20);
  endtask

  task automatic idle_controls();
    stall_id    = 1'b0;
    data_hazard = 1'b0;
    flush       = 1'b0;
    m_ready     = 1'b1;
    dmem_stall  = 1'b0;
  endtask

  // One clock with inputs already driven at the falling edge
  task automatic apply_cycle();
    id_ex_t nxt;
    logic   hold;
    nxt.dec      = ref_decode(fetch.instr);
    nxt.rs1_data = ref_operand(fetch.instr[19:15]);
    nxt.rs2_data = ref_operand(fetch.instr[24:20]);
    nxt.instr    = fetch.instr;
    nxt.pc       = fetch.pc;
    nxt.pc_plus4 = fetch.pc_plus4;
    hold         = stall_id || !m_ready;
    #1;
    check_src("src_o", ref_src(fetch.instr), src);
    @(posedge clk);
    if (flush) begin
      exp_valid        = 1'b0;
      exp_ex.dec.ctrl  = strip_side_effects(exp_ex.dec.ctrl);
    end else if (!hold) begin
      exp_ex    = nxt;
      exp_valid = data_hazard ? 1'b0 : fetch.valid;
      if (data_hazard) exp_ex.dec.ctrl = strip_side_effects(nxt.dec.ctrl);
    end
    if (wb.we && !dmem_stall && wb.rd != '0) shadow_regs[wb.rd] = wb.data;
    @(negedge clk);
    check_valid("m_valid_o", exp_valid, m_valid);
    check_ctrl("ex_o.dec.ctrl", exp_ex.dec.ctrl, ex.dec.ctrl);
    if (exp_valid) begin
      check_dec("ex_o.dec", exp_ex.dec, ex.dec);
      check_ex(exp_ex, ex);
    end
  endtask

  task automatic print_test_result(input string name, input int fails_before);
    $display("test %-8s done, %0d errors", name, fail_cnt - fails_before);
  endtask

  // ====================
  // Test sequence
  // ====================

  initial begin
    int fails_at;
    void'($urandom(32'h2835));
    pass_cnt  = 0;
    fail_cnt  = 0;
    cycle_cnt = 0;
    arst_n_i  = 1'b0;
    fetch     = '0;
    wb        = '0;
    mem       = '0;
    exp_ex    = '0;
    exp_valid = 1'b0;
    idle_controls();
    shadow_regs[0] = '0;

    fails_at = fail_cnt;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n_i = 1'b1;
    check_valid("m_valid_o", 1'b0, m_valid);
    check_ctrl("ex_o.dec.ctrl", '0, ex.dec.ctrl);
    print_test_result("reset", fails_at);

    // Fill every register before any operand is compared
    fails_at = fail_cnt;
    for (int n = 1; n <= RF_INIT_CYCLES; n++) begin
      drive_fetch(1'b0, rand_instr(0));
      wb = '{we: 1'b1, rd: 5'(n), data: $urandom()};
      apply_cycle();
    end
    for (int n = 0; n < RF_CYCLES; n++) begin
      drive_fetch(1'b1, {rand_instr(0)} & 32'hFFFF_FF80 | 32'(OPC_OP));
      wb         = '{we: chance(70), rd: 5'($urandom_range(31)), data: $urandom()};
      dmem_stall = chance(30);
      apply_cycle();
    end
    print_test_result("regfile", fails_at);

    fails_at = fail_cnt;
    idle_controls();
    wb  = '0;
    mem = '0;
    for (int n = 0; n < DEC_CYCLES; n++) begin
      drive_fetch(1'b1, rand_instr(10));
      apply_cycle();
    end
    print_test_result("decode", fails_at);

    fails_at = fail_cnt;
    for (int n = 0; n < FWD_CYCLES; n++) begin
      drive_fetch(1'b1, rand_instr(0));
      if (chance(10)) fetch.instr[19:15] = '0;
      if (chance(10)) fetch.instr[24:20] = '0;
      drive_bypass_sources();
      apply_cycle();
    end
    print_test_result("forward", fails_at);

    fails_at = fail_cnt;
    for (int n = 0; n < PIPE_CYCLES; n++) begin
      drive_fetch(chance(85), rand_instr(10));
      drive_bypass_sources();
      stall_id    = chance(20);
      m_ready     = !chance(20);
      data_hazard = chance(20);
      // EX still owns a valid instruction under back-pressure
      flush       = chance(10) && !(m_valid && !m_ready);
      apply_cycle();
    end
    print_test_result("pipeline", fails_at);

    $display("checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* rv_stage_id.f */
+incdir+logic
logic/rv_id_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_operand_fwd.sv
logic/rv_id_ex_reg.sv
logic/rv_stage_id.sv
tb/tb_rv_stage_id.sv

/* Makefile */
# Verilator flow for the RV32I decode stage

VERILATOR ?= verilator
FILELIST  ?= rv_stage_id.f
TB_TOP    ?= tb_rv_stage_id
RTL_TOP   ?= rv_stage_id
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= >>> PASS
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -qF -- "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
